// File: source/mxu_pkg.sv
`default_nettype none

package mxu_pkg;

    //////////////////////////////////////////////////
    // element format
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        prec_none  = 2'd0,
        prec_int8  = 2'd1,
        prec_int16 = 2'd2,
        prec_int32 = 2'd3
    } precision_e;

    //////////////////////////////////////////////////
    // configuration registers
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       chain;
        logic [4:0] reserved;
        precision_e precision;
    } csr_mode_t;

    // one register word, read as mode or as vector count
    typedef union packed {
        csr_mode_t  mode;
        logic [7:0] count;
    } csr_word_u;

    typedef enum logic {
        a_mode  = 1'b0,
        a_count = 1'b1
    } csr_addr_t;

    //////////////////////////////////////////////////
    // datapath types
    //////////////////////////////////////////////////

    typedef logic        [31:0] word_t;
    typedef logic signed [31:0] elem_t;
    typedef logic signed [15:0] weight_t;
    typedef logic signed [31:0] acc_t;

    // latched once per job
    typedef struct packed {
        precision_e precision;
        logic       chain;
    } job_cfg_t;

    typedef struct packed {
        logic clear;
        logic step;
        logic last;
    } mac_ctrl_t;

endpackage

`default_nettype wire

// File: source/csr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module csr_bank (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  mxu_pkg::csr_addr_t csr_waddr,
    input  logic [7:0]         csr_wdata,
    input  mxu_pkg::csr_addr_t csr_raddr,
    output mxu_pkg::csr_word_u csr_rdata
);

    mxu_pkg::csr_mode_t mode_q;
    logic [7:0]         count_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            mode_q    <= '{chain: 1'b0, reserved: '0, precision: mxu_pkg::prec_none};
            count_q   <= '0;
            csr_rdata <= '0;
        end else begin
            // host writes
            if (csr_we && csr_waddr == mxu_pkg::a_mode) begin
                mode_q <= mxu_pkg::csr_mode_t'(csr_wdata);
            end
            if (csr_we && csr_waddr == mxu_pkg::a_count) begin
                count_q <= csr_wdata;
            end

            // read data one cycle after the address
            if (csr_raddr == mxu_pkg::a_mode) begin
                csr_rdata.mode <= mode_q;
            end else begin
                csr_rdata.count <= count_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/weight_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_buffer #(
    parameter int ROWS    = 4,
    parameter int COLUMNS = 8
) (
    input  logic                           clk,
    input  logic                           wm_we,
    input  logic [$clog2(ROWS)-1:0]        wm_row,
    input  logic [$clog2(COLUMNS)-1:0]     wm_col,
    input  mxu_pkg::weight_t               wm_wdata,
    input  logic [$clog2(COLUMNS)-1:0]     col_addr,
    output mxu_pkg::weight_t [ROWS-1:0]    weight_col
);

    mxu_pkg::weight_t mem [ROWS][COLUMNS];

    // host write port
    always_ff @(posedge clk) begin
        if (wm_we) begin
            mem[wm_row][wm_col] <= wm_wdata;
        end
    end

    // whole column per cycle, registered
    always_ff @(posedge clk) begin
        for (int r = 0; r < ROWS; r++) begin
            weight_col[r] <= mem[r][col_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/activation_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module activation_unpacker #(
    parameter int IN_CREDITS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  mxu_pkg::job_cfg_t job_cfg,
    input  logic              in_valid,
    input  mxu_pkg::word_t    in_data,
    output logic              in_credit,
    input  logic              elem_pop,
    output logic              elem_avail,
    output mxu_pkg::elem_t    elem
);

    localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int CNT_W = $clog2(IN_CREDITS + 1);

    mxu_pkg::word_t   slots [IN_CREDITS];
    mxu_pkg::word_t   head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [1:0]       sub;
    logic             word_done;

    assign head       = slots[rd_ptr];
    assign elem_avail = (fill != '0);

    // last element of the head word
    always_comb begin
        case (job_cfg.precision)
            mxu_pkg::prec_int8:  word_done = (sub == 2'd3);
            mxu_pkg::prec_int16: word_done = (sub == 2'd1);
            default:             word_done = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            slots[wr_ptr] <= in_data;
        end
    end

    // sign extended from the packed width
    always_ff @(posedge clk) begin
        if (elem_pop) begin
            case (job_cfg.precision)
                mxu_pkg::prec_int8:  elem <= $signed(head[8*sub +: 8]);
                mxu_pkg::prec_int16: elem <= $signed(head[16*sub[0] +: 16]);
                default:             elem <= head;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // pointers, fill level and credit return
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            sub       <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= elem_pop && word_done;
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (elem_pop) begin
                if (word_done) begin
                    sub    <= '0;
                    rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
                end else begin
                    sub <= sub + 1'b1;
                end
            end
            fill <= fill + CNT_W'(in_valid) - CNT_W'(elem_pop && word_done);
        end
    end

    // sender must hold a credit for every word
    assert property (@(posedge clk) disable iff (!reset)
        in_valid |-> (fill < CNT_W'(IN_CREDITS)))
        else $error("input word arrived with the buffer full");

endmodule

`default_nettype wire

// File: source/mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module mac_array #(
    parameter int ROWS = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  mxu_pkg::mac_ctrl_t          mac_ctrl,
    input  mxu_pkg::elem_t              elem,
    input  mxu_pkg::weight_t [ROWS-1:0] weight_col,
    output mxu_pkg::acc_t [ROWS-1:0]    row_results,
    output logic                        results_valid
);

    mxu_pkg::acc_t [ROWS-1:0] products;

    // wraps to 32 bits
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            products[r] = $signed(weight_col[r]) * elem;
        end
    end

    // one accumulator per row
    always_ff @(posedge clk) begin
        if (mac_ctrl.step) begin
            for (int r = 0; r < ROWS; r++) begin
                if (mac_ctrl.clear) begin
                    row_results[r] <= products[r];
                end else begin
                    row_results[r] <= row_results[r] + products[r];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            results_valid <= 1'b0;
        end else begin
            results_valid <= mac_ctrl.step && mac_ctrl.last;
        end
    end

endmodule

`default_nettype wire

// File: source/result_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module result_streamer #(
    parameter int ROWS        = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  mxu_pkg::acc_t [ROWS-1:0] row_results,
    input  logic                     results_valid,
    input  logic                     out_credit,
    output logic                     out_valid,
    output mxu_pkg::word_t           out_data,
    output logic                     busy
);

    localparam int IDX_W = (ROWS > 1) ? $clog2(ROWS) : 1;
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    mxu_pkg::acc_t [ROWS-1:0] snapshot;
    logic [IDX_W-1:0]         idx;
    logic [CRD_W-1:0]         credits;
    logic                     send;

    assign send = busy && (credits != '0);

    always_ff @(posedge clk) begin
        if (results_valid) begin
            snapshot <= row_results;
        end
        if (send) begin
            out_data <= snapshot[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy      <= 1'b0;
            idx       <= '0;
            out_valid <= 1'b0;
            credits   <= CRD_W'(OUT_CREDITS);
        end else begin
            out_valid <= send;
            credits   <= credits + CRD_W'(out_credit) - CRD_W'(send);
            if (results_valid) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (send) begin
                // row 0 first
                if (idx == IDX_W'(ROWS - 1)) begin
                    busy <= 1'b0;
                end
                idx <= idx + 1'b1;
            end
        end
    end

    // never more credits than the consumer granted
    assert property (@(posedge clk) disable iff (!reset)
        credits <= CRD_W'(OUT_CREDITS))
        else $error("output credit returned beyond the initial grant");

    // control holds the last step until the snapshot is drained
    assert property (@(posedge clk) disable iff (!reset)
        results_valid |-> !busy)
        else $error("new results while still streaming");

endmodule

`default_nettype wire

// File: source/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
    parameter int COLUMNS = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       glb_enable,
    input  logic                       cs_start,
    output logic                       cs_idle,
    output logic                       cs_ready,
    output logic                       cs_done,
    output mxu_pkg::csr_addr_t         csr_raddr,
    input  mxu_pkg::csr_word_u         csr_rdata,
    output mxu_pkg::job_cfg_t          job_cfg,
    input  logic                       elem_avail,
    output logic                       elem_pop,
    output logic [$clog2(COLUMNS)-1:0] col_addr,
    output mxu_pkg::mac_ctrl_t         mac_ctrl,
    input  logic                       streamer_busy
);

    localparam int COL_W = $clog2(COLUMNS);

    typedef enum logic [2:0] {
        s_idle,
        s_rd_mode,
        s_rd_count,
        s_ready,
        s_compute,
        s_drain
    } state_e;

    state_e           state;
    logic [COL_W-1:0] col_q;
    logic [7:0]       vec_left;
    logic             first_step;
    logic [1:0]       drain_wait;
    logic             last_col;

    assign last_col  = (col_q == COL_W'(COLUMNS - 1));
    assign col_addr  = col_q;
    assign cs_ready  = (state == s_ready);
    assign csr_raddr = (state == s_rd_mode) ? mxu_pkg::a_mode : mxu_pkg::a_count;

    // last column waits for a free streamer
    assign elem_pop = (state == s_compute) && elem_avail && !(last_col && streamer_busy);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= s_idle;
            cs_idle    <= 1'b0;
            cs_done    <= 1'b0;
            job_cfg    <= '0;
            col_q      <= '0;
            vec_left   <= '0;
            first_step <= 1'b0;
            drain_wait <= '0;
            mac_ctrl   <= '0;
        end else begin
            cs_idle <= (state == s_idle);
            cs_done <= 1'b0;

            // datapath control lags the pop by one cycle
            mac_ctrl.step  <= elem_pop;
            mac_ctrl.last  <= elem_pop && last_col;
            mac_ctrl.clear <= elem_pop && (col_q == '0) && (first_step || !job_cfg.chain);

            case (state)
                s_idle: begin
                    if (cs_start && glb_enable) begin
                        state <= s_rd_mode;
                    end
                end
                s_rd_mode: begin
                    state <= cs_start ? s_rd_count : s_idle;
                end
                s_rd_count: begin
                    // mode word is on the read port now
                    job_cfg.precision <= csr_rdata.mode.precision;
                    job_cfg.chain     <= csr_rdata.mode.chain;
                    state             <= cs_start ? s_ready : s_idle;
                end
                s_ready: begin
                    vec_left   <= csr_rdata.count;
                    col_q      <= '0;
                    first_step <= 1'b1;
                    drain_wait <= 2'd2;
                    if (job_cfg.precision == mxu_pkg::prec_none || csr_rdata.count == '0) begin
                        state <= s_drain;
                    end else begin
                        state <= s_compute;
                    end
                end
                s_compute: begin
                    if (elem_pop) begin
                        first_step <= 1'b0;
                        col_q      <= last_col ? '0 : col_q + 1'b1;
                        if (last_col) begin
                            vec_left <= vec_left - 1'b1;
                            if (vec_left == 8'd1) begin
                                state      <= s_drain;
                                drain_wait <= 2'd2;
                            end
                        end
                    end
                end
                s_drain: begin
                    // let the final results reach the streamer
                    if (drain_wait != '0) begin
                        drain_wait <= drain_wait - 1'b1;
                    end else if (!streamer_busy) begin
                        cs_done <= 1'b1;
                        state   <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // a finished vector only goes to a free streamer
    assert property (@(posedge clk) disable iff (!reset)
        mac_ctrl.last |-> !streamer_busy)
        else $error("last step while the streamer is busy");

endmodule

`default_nettype wire

// File: source/mxu_accel.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_accel #(
    parameter int ROWS        = 4,
    parameter int COLUMNS     = 8,
    parameter int IN_CREDITS  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       csr_we,
    input  mxu_pkg::csr_addr_t         csr_waddr,
    input  logic [7:0]                 csr_wdata,
    input  logic                       wm_we,
    input  logic [$clog2(ROWS)-1:0]    wm_row,
    input  logic [$clog2(COLUMNS)-1:0] wm_col,
    input  mxu_pkg::weight_t           wm_wdata,
    input  logic                       cs_start,
    input  logic                       glb_enable,
    output logic                       cs_idle,
    output logic                       cs_ready,
    output logic                       cs_done,
    input  logic                       in_valid,
    input  mxu_pkg::word_t             in_data,
    output logic                       in_credit,
    output logic                       out_valid,
    output mxu_pkg::word_t             out_data,
    input  logic                       out_credit
);

    mxu_pkg::csr_addr_t          csr_raddr;
    mxu_pkg::csr_word_u          csr_rdata;
    mxu_pkg::job_cfg_t           job_cfg;
    logic                        elem_pop;
    logic                        elem_avail;
    mxu_pkg::elem_t              elem;
    logic [$clog2(COLUMNS)-1:0]  col_addr;
    mxu_pkg::weight_t [ROWS-1:0] weight_col;
    mxu_pkg::mac_ctrl_t          mac_ctrl;
    mxu_pkg::acc_t [ROWS-1:0]    row_results;
    logic                        results_valid;
    logic                        streamer_busy;

    //////////////////////////////////////////////////
    // configuration and control
    //////////////////////////////////////////////////

    csr_bank i_csr_bank (
        .clk       (clk),
        .reset     (reset),
        .csr_we    (csr_we),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata)
    );

    control_unit #(
        .COLUMNS (COLUMNS)
    ) i_control_unit (
        .clk           (clk),
        .reset         (reset),
        .glb_enable    (glb_enable),
        .cs_start      (cs_start),
        .cs_idle       (cs_idle),
        .cs_ready      (cs_ready),
        .cs_done       (cs_done),
        .csr_raddr     (csr_raddr),
        .csr_rdata     (csr_rdata),
        .job_cfg       (job_cfg),
        .elem_avail    (elem_avail),
        .elem_pop      (elem_pop),
        .col_addr      (col_addr),
        .mac_ctrl      (mac_ctrl),
        .streamer_busy (streamer_busy)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    weight_buffer #(
        .ROWS    (ROWS),
        .COLUMNS (COLUMNS)
    ) i_weight_buffer (
        .clk        (clk),
        .wm_we      (wm_we),
        .wm_row     (wm_row),
        .wm_col     (wm_col),
        .wm_wdata   (wm_wdata),
        .col_addr   (col_addr),
        .weight_col (weight_col)
    );

    activation_unpacker #(
        .IN_CREDITS (IN_CREDITS)
    ) i_activation_unpacker (
        .clk        (clk),
        .reset      (reset),
        .job_cfg    (job_cfg),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .elem_pop   (elem_pop),
        .elem_avail (elem_avail),
        .elem       (elem)
    );

    mac_array #(
        .ROWS (ROWS)
    ) i_mac_array (
        .clk           (clk),
        .reset         (reset),
        .mac_ctrl      (mac_ctrl),
        .elem          (elem),
        .weight_col    (weight_col),
        .row_results   (row_results),
        .results_valid (results_valid)
    );

    result_streamer #(
        .ROWS        (ROWS),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_result_streamer (
        .clk           (clk),
        .reset         (reset),
        .row_results   (row_results),
        .results_valid (results_valid),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .busy          (streamer_busy)
    );

endmodule

`default_nettype wire

// File: tb/mxu_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_accel_tb;

    localparam int ROWS          = 4;
    localparam int COLUMNS       = 8;
    localparam int IN_CREDITS    = 4;
    localparam int OUT_CREDITS   = 2;
    localparam int SEED          = 32'hd646;
    // vectors over all tests, one extra slot for reset and the empty jobs
    localparam int TOTAL_VECTORS = 1 + 3 + 3 + 4 + 3 + 1;
    localparam int WATCHDOG      = (TOTAL_VECTORS + 1) * 200;

    logic               clk = 1'b0;
    logic               reset;
    logic               csr_we;
    mxu_pkg::csr_addr_t csr_waddr;
    logic [7:0]         csr_wdata;
    logic               wm_we;
    logic [1:0]         wm_row;
    logic [2:0]         wm_col;
    mxu_pkg::weight_t   wm_wdata;
    logic               cs_start;
    logic               glb_enable;
    logic               cs_idle;
    logic               cs_ready;
    logic               cs_done;
    logic               in_valid = 1'b0;
    mxu_pkg::word_t     in_data = '0;
    logic               in_credit;
    logic               out_valid;
    mxu_pkg::word_t     out_data;
    logic               out_credit = 1'b0;

    // stream models and bookkeeping
    mxu_pkg::weight_t weights [ROWS][COLUMNS];
    logic [31:0]      send_q [$];
    logic [31:0]      got_q [$];
    int               due_q [$];
    int               in_credits_held = IN_CREDITS;
    int               out_credits_held = OUT_CREDITS;
    int               words_sent = 0;
    int               credit_pulses = 0;
    int               ready_pulses = 0;
    int               done_pulses = 0;
    int               cycle_count = 0;
    int               credit_delay = 2;
    logic             stall_mode = 1'b0;

    mxu_accel #(
        .ROWS        (ROWS),
        .COLUMNS     (COLUMNS),
        .IN_CREDITS  (IN_CREDITS),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_mxu_accel (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_waddr  (csr_waddr),
        .csr_wdata  (csr_wdata),
        .wm_we      (wm_we),
        .wm_row     (wm_row),
        .wm_col     (wm_col),
        .wm_wdata   (wm_wdata),
        .cs_start   (cs_start),
        .glb_enable (glb_enable),
        .cs_idle    (cs_idle),
        .cs_ready   (cs_ready),
        .cs_done    (cs_done),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s (got %h, expected %h)", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // stream models, all on the falling edge
    //////////////////////////////////////////////////

    // one word per held credit
    always @(negedge clk) begin
        if (in_credit === 1'b1) begin
            in_credits_held++;
            credit_pulses++;
        end
        if (send_q.size() > 0 && in_credits_held > 0) begin
            in_data = send_q.pop_front();
            in_valid = 1'b1;
            in_credits_held--;
            words_sent++;
        end else begin
            in_valid = 1'b0;
        end
    end

    // consumer hands each credit back after a delay
    always @(negedge clk) begin
        cycle_count++;
        if (out_valid === 1'b1) begin
            check_value(32'(out_credits_held > 0), 32'd1, "out_valid with no credit held");
            out_credits_held--;
            got_q.push_back(out_data);
            due_q.push_back(cycle_count + (stall_mode ? 32'($urandom_range(24, 1)) : credit_delay));
        end
        if (due_q.size() > 0 && due_q[0] <= cycle_count) begin
            void'(due_q.pop_front());
            out_credit = 1'b1;
            out_credits_held++;
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (cs_ready === 1'b1) begin
            ready_pulses++;
        end
        if (cs_done === 1'b1) begin
            done_pulses++;
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("TEST FAILED");
        $fatal(1, "timeout: the tests did not finish within %0d cycles", WATCHDOG);
    end

    //////////////////////////////////////////////////
    // host side tasks
    //////////////////////////////////////////////////

    task automatic write_csr(input mxu_pkg::csr_addr_t addr, input logic [7:0] data);
        csr_we    = 1'b1;
        csr_waddr = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic load_weights();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLUMNS; c++) begin
                weights[r][c] = 16'($urandom);
                wm_we    = 1'b1;
                wm_row   = 2'(r);
                wm_col   = 3'(c);
                wm_wdata = weights[r][c];
                @(negedge clk);
            end
        end
        wm_we = 1'b0;
    endtask

    // ready comes exactly three cycles after start
    task automatic start_job();
        cs_start = 1'b1;
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            check_value(32'(cs_ready), (i == 3) ? 32'd1 : 32'd0, "cs_ready timing");
        end
        cs_start = 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (cs_done !== 1'b1);
        @(negedge clk);
        check_value(32'(cs_idle), 32'd1, "cs_idle one cycle after cs_done");
    endtask

    function automatic logic signed [31:0] random_element(input mxu_pkg::precision_e prec);
        logic [31:0]        r;
        logic signed [7:0]  b;
        logic signed [15:0] h;
        r = $urandom;
        b = r[7:0];
        h = r[15:0];
        case (prec)
            mxu_pkg::prec_int8:  return b;
            mxu_pkg::prec_int16: return h;
            default:             return r;
        endcase
    endfunction

    // words of the following job already wait in the input buffer
    task automatic prec_none_job();
        int pulses_before;
        pulses_before = credit_pulses;
        write_csr(mxu_pkg::a_mode, 8'h00);
        write_csr(mxu_pkg::a_count, 8'd2);
        got_q.delete();
        start_job();
        wait_done();
        check_value(32'(got_q.size()), 32'd0, "output words from a prec_none job");
        check_value(32'(credit_pulses), 32'(pulses_before), "in_credit from a prec_none job");
    endtask

    // random weights and vectors, packed low lane first
    task automatic run_job(input mxu_pkg::precision_e prec, input logic chain, input int count,
                           input logic empty_first);
        mxu_pkg::csr_mode_t mode;
        logic signed [31:0] e [COLUMNS];
        logic signed [31:0] acc [ROWS];
        logic [31:0]        expected_q [$];
        logic [31:0]        word;
        logic [31:0]        mask;
        int                 width;
        int                 lanes;
        width = (prec == mxu_pkg::prec_int8) ? 8 : (prec == mxu_pkg::prec_int16) ? 16 : 32;
        lanes = 32 / width;
        mask  = (width == 32) ? 32'hffff_ffff : (32'h1 << width) - 32'h1;
        load_weights();
        got_q.delete();
        for (int v = 0; v < count; v++) begin
            word = '0;
            for (int k = 0; k < COLUMNS; k++) begin
                e[k] = random_element(prec);
                word = word | ((e[k] & mask) << (width * (k % lanes)));
                if (k % lanes == lanes - 1) begin
                    send_q.push_back(word);
                    word = '0;
                end
            end
            // reference dot products, chain keeps the running sum
            for (int r = 0; r < ROWS; r++) begin
                if (!chain || v == 0) begin
                    acc[r] = '0;
                end
                for (int c = 0; c < COLUMNS; c++) begin
                    acc[r] = acc[r] + weights[r][c] * e[c];
                end
                expected_q.push_back(acc[r]);
            end
        end
        if (empty_first) begin
            prec_none_job();
        end
        mode = '{chain: chain, reserved: '0, precision: prec};
        write_csr(mxu_pkg::a_mode, mode);
        write_csr(mxu_pkg::a_count, 8'(count));
        start_job();
        wait_done();
        check_value(32'(got_q.size()), 32'(expected_q.size()), "number of result words");
        foreach (expected_q[i]) begin
            check_value(got_q[i], expected_q[i], $sformatf("result word %0d", i));
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic backpressure_test();
        stall_mode = 1'b1;
        run_job(mxu_pkg::prec_int16, 1'b0, 3, 1'b0);
        stall_mode = 1'b0;
    endtask

    task automatic empty_job_test();
        run_job(mxu_pkg::prec_int16, 1'b0, 1, 1'b1);
    endtask

    task automatic aborted_start_test();
        int ready_before;
        int done_before;
        write_csr(mxu_pkg::a_mode, 8'h01);
        write_csr(mxu_pkg::a_count, 8'd1);
        ready_before = ready_pulses;
        done_before  = done_pulses;
        cs_start = 1'b1;
        @(negedge clk);
        cs_start = 1'b0;
        repeat (8) @(negedge clk);
        check_value(32'(ready_pulses), 32'(ready_before), "cs_ready after an aborted start");
        check_value(32'(done_pulses), 32'(done_before), "cs_done after an aborted start");
        check_value(32'(cs_idle), 32'd1, "cs_idle after an aborted start");
    endtask

    initial begin
        void'($urandom(SEED));
        reset      = 1'b0;
        glb_enable = 1'b1;
        cs_start   = 1'b0;
        csr_we     = 1'b0;
        csr_waddr  = mxu_pkg::a_mode;
        csr_wdata  = '0;
        wm_we      = 1'b0;
        wm_row     = '0;
        wm_col     = '0;
        wm_wdata   = '0;
        repeat (5) @(negedge clk);
        check_value({cs_ready, cs_done, out_valid, in_credit}, '0, "outputs during reset");
        reset = 1'b1;
        @(negedge clk);
        check_value(32'(cs_idle), 32'd1, "cs_idle after reset");

        run_job(mxu_pkg::prec_int8, 1'b0, 1, 1'b0);
        run_job(mxu_pkg::prec_int16, 1'b0, 3, 1'b0);
        run_job(mxu_pkg::prec_int32, 1'b0, 3, 1'b0);
        run_job(mxu_pkg::prec_int8, 1'b1, 4, 1'b0);
        backpressure_test();
        empty_job_test();
        aborted_start_test();

        // every word sent got its credit back
        check_value(32'(credit_pulses), 32'(words_sent), "in_credit pulses against words sent");
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mxu_accel.f
source/mxu_pkg.sv
source/csr_bank.sv
source/weight_buffer.sv
source/activation_unpacker.sv
source/mac_array.sv
source/result_streamer.sv
source/control_unit.sv
source/mxu_accel.sv
tb/mxu_accel_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mxu_accel testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f mxu_accel.f \
    --top-module mxu_accel_tb -o mxu_accel_sim || { echo "build failed"; exit 1; }

./obj_dir/mxu_accel_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
